// File: common/g729Pkg.sv
package g729Pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  // Q15 values and basic-op operands
  localparam int WORD_W = 16;

  ////////////////////////////////////////
  // lsp_lsf2 constants
  ////////////////////////////////////////

  localparam int LPC_ORDER = 10;
  localparam int COEF_W = $clog2(LPC_ORDER);
  localparam int TABLE_SIZE = 64;
  localparam int IDX_W = $clog2(TABLE_SIZE);
  localparam int INIT_IND = 63;
  localparam int LSF_SCALE = 25736;
  // Slope product is Q28, back to Q16 by this shift
  localparam int SLOPE_SHIFT = 12;
  localparam int IND_SHIFT = 9;
  localparam int CALC_STEPS = 6;
  // Cosine entry in the upper half, acos slope in the lower half
  localparam string TABLE_FILE = "common/lspTables.mem";

  typedef enum logic [2:0] {
    OP_SUB,
    OP_ADD,
    OP_SHL,
    OP_MULT,
    OP_LMULT,
    OP_LSHR
  } opCode;

  typedef enum logic [2:0] {
    IDLE,
    READ_LSP,
    SEARCH,
    CALC,
    WRITE_LSF,
    DONE
  } ctrlState;

  // Widen a 16-bit word to a memory or operand word
  function automatic logic [DATA_W-1:0] sext(input logic [WORD_W-1:0] v);
    return {{(DATA_W-WORD_W){v[WORD_W-1]}}, v};
  endfunction

endpackage

// File: verilog/basicOps.sv
`timescale 1ns/1ns

module basicOps import g729Pkg::*;
(
  input  opCode             opSel,
  input  logic [DATA_W-1:0] opA,
  input  logic [DATA_W-1:0] opB,
  output logic [DATA_W-1:0] opResult
);

  logic signed [WORD_W-1:0]   a16;
  logic signed [WORD_W-1:0]   b16;
  logic signed [DATA_W-1:0]   aExt;
  logic signed [DATA_W-1:0]   bExt;
  logic signed [DATA_W-1:0]   a32;
  logic signed [DATA_W-1:0]   prod;
  logic signed [DATA_W-1:0]   shlWide;
  logic signed [2*DATA_W-1:0] lShlWide;
  logic [3:0]                 shrAmt;
  logic [4:0]                 lShrAmt;
  logic [5:0]                 lShlAmt;

  function automatic logic [WORD_W-1:0] sat16(input logic signed [DATA_W-1:0] v);
    if (v > 32'sd32767)
      return 16'h7fff;
    else if (v < -32'sd32768)
      return 16'h8000;
    else
      return v[WORD_W-1:0];
  endfunction

  assign a16  = opA[WORD_W-1:0];
  assign b16  = opB[WORD_W-1:0];
  assign aExt = sext(opA[WORD_W-1:0]);
  assign bExt = sext(opB[WORD_W-1:0]);
  assign a32  = opA;
  assign prod = aExt * bExt;

  // Shift counts clamped to where the result no longer changes
  assign shrAmt   = (b16 < -16'sd15) ? 4'd15 : 4'(-b16);
  assign lShrAmt  = (b16 > 16'sd31) ? 5'd31 : 5'(b16);
  assign lShlAmt  = (b16 < -16'sd32) ? 6'd32 : 6'(-b16);
  assign shlWide  = aExt <<< b16[3:0];
  assign lShlWide = {{DATA_W{a32[DATA_W-1]}}, a32} << lShlAmt;

  always_comb
  begin
    opResult = '0;
    case (opSel)
      OP_SUB:  opResult = sext(sat16(aExt - bExt));
      OP_ADD:  opResult = sext(sat16(aExt + bExt));
      OP_SHL:
      begin
        if (b16 < 16'sd0)
          opResult = aExt >>> shrAmt;
        else if (b16 > 16'sd15)
          opResult = (a16 == '0) ? '0 : sext((a16 > 16'sd0) ? 16'h7fff : 16'h8000);
        else
          opResult = sext(sat16(shlWide));
      end
      // Q15 product, only -1 * -1 saturates
      OP_MULT: opResult = sext(sat16(prod >>> 15));
      OP_LMULT: opResult = (prod == 32'sh40000000) ? 32'h7fffffff : prod <<< 1;
      OP_LSHR:
      begin
        if (b16 >= 16'sd0)
          opResult = a32 >>> lShrAmt;
        else if (lShlWide > 64'sd2147483647)
          opResult = 32'h7fffffff;
        else if (lShlWide < -64'sd2147483648)
          opResult = 32'h80000000;
        else
          opResult = lShlWide[DATA_W-1:0];
      end
      default: opResult = '0;
    endcase
  end

endmodule

// File: verilog/scratchMemory.sv
`timescale 1ns/1ns

module scratchMemory import g729Pkg::*;
(
  input  logic              clk,
  input  logic              testSel,
  input  logic [ADDR_W-1:0] testReadAddr,
  input  logic [ADDR_W-1:0] testWriteAddr,
  input  logic [DATA_W-1:0] testWriteData,
  input  logic              testWriteEn,
  input  logic [ADDR_W-1:0] seqReadAddr,
  input  logic [ADDR_W-1:0] seqWriteAddr,
  input  logic [DATA_W-1:0] seqWriteData,
  input  logic              seqWriteEn,
  output logic [DATA_W-1:0] readData
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  logic [ADDR_W-1:0] readAddr;
  logic [ADDR_W-1:0] writeAddr;
  logic [DATA_W-1:0] writeData;
  logic              writeEn;

  // Test port owns the memory while testSel is high
  assign readAddr  = testSel ? testReadAddr : seqReadAddr;
  assign writeAddr = testSel ? testWriteAddr : seqWriteAddr;
  assign writeData = testSel ? testWriteData : seqWriteData;
  assign writeEn   = testSel ? testWriteEn : seqWriteEn;

  // Read returns the old word on a same-address write
  always_ff @(posedge clk)
  begin
    if (writeEn)
      mem[writeAddr] <= writeData;
    readData <= mem[readAddr];
  end

  assert property (@(posedge clk) writeEn |-> !$isunknown(writeAddr));

endmodule

// File: verilog/constantRom.sv
`timescale 1ns/1ns

module constantRom import g729Pkg::*;
(
  input  logic              clk,
  input  logic [IDX_W-1:0]  romAddr,
  output logic [DATA_W-1:0] romData
);

  // Cosine table and acos slopes, one pair per word
  logic [DATA_W-1:0] rom [TABLE_SIZE];

  initial
  begin
    $readmemh(TABLE_FILE, rom);
  end

  always_ff @(posedge clk)
  begin
    romData <= rom[romAddr];
  end

endmodule

// File: lspLsf/lspLsfControl.sv
`timescale 1ns/1ns

module lspLsfControl import g729Pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [ADDR_W-1:0] lspAddr,
  input  logic [ADDR_W-1:0] lsfAddr,
  input  logic [DATA_W-1:0] memReadData,
  input  logic [DATA_W-1:0] romData,
  input  logic [DATA_W-1:0] opResult,
  output opCode             opSel,
  output logic [DATA_W-1:0] opA,
  output logic [DATA_W-1:0] opB,
  output logic [ADDR_W-1:0] memReadAddr,
  output logic [ADDR_W-1:0] memWriteAddr,
  output logic [DATA_W-1:0] memWriteData,
  output logic              memWriteEn,
  output logic [IDX_W-1:0]  romAddr,
  output logic              done,
  output logic              busy
);

  ctrlState          state;
  // Address cycle then data cycle, for both LSP read and search
  logic              phase;
  logic [2:0]        step;
  logic [COEF_W-1:0] coef;
  logic [IDX_W-1:0]  ind;

  logic signed [WORD_W-1:0] lsp;
  logic signed [WORD_W-1:0] tableEntry;
  logic signed [WORD_W-1:0] slope;
  logic [DATA_W-1:0]        acc;
  // Holds shl(ind, 9) until the add
  logic [WORD_W-1:0]        freqHi;

  assign tableEntry  = romData[DATA_W-1:WORD_W];
  assign slope       = romData[WORD_W-1:0];
  assign romAddr     = ind;
  assign memReadAddr = lspAddr + ADDR_W'(coef);

  ////////////////////////////////////////
  // Operation schedule
  ////////////////////////////////////////

  always_comb
  begin
    opSel = OP_SUB;
    opA   = sext(lsp);
    opB   = sext(tableEntry);
    case (step)
      3'd1:
      begin
        // L_mult(slope, offset)
        opSel = OP_LMULT;
        opA   = sext(slope);
        opB   = acc;
      end
      3'd2:
      begin
        opSel = OP_LSHR;
        opA   = acc;
        opB   = DATA_W'(SLOPE_SHIFT);
      end
      3'd3:
      begin
        opSel = OP_SHL;
        opA   = DATA_W'(ind);
        opB   = DATA_W'(IND_SHIFT);
      end
      3'd4:
      begin
        // Low half of acc is extract_l of the shifted product
        opSel = OP_ADD;
        opA   = sext(freqHi);
        opB   = acc;
      end
      3'd5:
      begin
        opSel = OP_MULT;
        opA   = acc;
        opB   = DATA_W'(LSF_SCALE);
      end
      default:
      begin
        opSel = OP_SUB;
      end
    endcase
  end

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= IDLE;
      phase      <= 1'b0;
      step       <= '0;
      coef       <= '0;
      ind        <= IDX_W'(INIT_IND);
      busy       <= 1'b0;
      done       <= 1'b0;
      memWriteEn <= 1'b0;
    end
    else
    begin
      done       <= 1'b0;
      memWriteEn <= 1'b0;
      case (state)
        IDLE:
          if (start)
          begin
            busy  <= 1'b1;
            ind   <= IDX_W'(INIT_IND);
            coef  <= COEF_W'(LPC_ORDER - 1);
            phase <= 1'b0;
            state <= READ_LSP;
          end
        READ_LSP:
        begin
          phase <= ~phase;
          if (phase)
            state <= SEARCH;
        end
        SEARCH:
        begin
          phase <= ~phase;
          // Walk down the cosine table, index carries over to the next coefficient
          if (phase)
          begin
            if (tableEntry < lsp && ind != '0)
              ind <= ind - 1'b1;
            else
            begin
              step  <= '0;
              state <= CALC;
            end
          end
        end
        CALC:
        begin
          if (step == 3'(CALC_STEPS - 1))
          begin
            step       <= '0;
            memWriteEn <= 1'b1;
            state      <= WRITE_LSF;
          end
          else
            step <= step + 1'b1;
        end
        WRITE_LSF:
          if (coef == '0)
          begin
            busy  <= 1'b0;
            done  <= 1'b1;
            state <= DONE;
          end
          else
          begin
            coef  <= coef - 1'b1;
            state <= READ_LSP;
          end
        DONE:
          state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk)
  begin
    if (state == READ_LSP && phase)
      lsp <= memReadData[WORD_W-1:0];
    if (state == CALC)
    begin
      case (step)
        3'd3: freqHi <= opResult[WORD_W-1:0];
        3'd5:
        begin
          memWriteData <= opResult;
          memWriteAddr <= lsfAddr + ADDR_W'(coef);
        end
        default: acc <= opResult;
      endcase
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  assert property (@(posedge clk) disable iff (rst) done |=> !done);

  // Index only moves down during a conversion, so it cannot wrap out of the table
  assert property (@(posedge clk) disable iff (rst)
    (state != IDLE) |=> (ind <= $past(ind)));

  assert property (@(posedge clk) disable iff (rst) memWriteEn |-> (state == WRITE_LSF));

endmodule

// File: lspLsf/lspLsfPipe.sv
`timescale 1ns/1ns

module lspLsfPipe import g729Pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [ADDR_W-1:0] lspAddr,
  input  logic [ADDR_W-1:0] lsfAddr,
  input  logic              testSel,
  input  logic [ADDR_W-1:0] testReadAddr,
  input  logic [ADDR_W-1:0] testWriteAddr,
  input  logic [DATA_W-1:0] testWriteData,
  input  logic              testWriteEn,
  output logic              done,
  output logic              busy,
  output logic [DATA_W-1:0] memReadData
);

  // Execute stage operands
  opCode             opSel;
  logic [DATA_W-1:0] opA;
  logic [DATA_W-1:0] opB;
  logic [DATA_W-1:0] opResult;

  // Sequencer side of the scratch memory
  logic [ADDR_W-1:0] memReadAddr;
  logic [ADDR_W-1:0] memWriteAddr;
  logic [DATA_W-1:0] memWriteData;
  logic              memWriteEn;

  logic [IDX_W-1:0]  romAddr;
  logic [DATA_W-1:0] romData;

  lspLsfControl fsm (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .lspAddr      (lspAddr),
    .lsfAddr      (lsfAddr),
    .memReadData  (memReadData),
    .romData      (romData),
    .opResult     (opResult),
    .opSel        (opSel),
    .opA          (opA),
    .opB          (opB),
    .memReadAddr  (memReadAddr),
    .memWriteAddr (memWriteAddr),
    .memWriteData (memWriteData),
    .memWriteEn   (memWriteEn),
    .romAddr      (romAddr),
    .done         (done),
    .busy         (busy)
  );

  basicOps alu (
    .opSel    (opSel),
    .opA      (opA),
    .opB      (opB),
    .opResult (opResult)
  );

  scratchMemory scratchMem (
    .clk           (clk),
    .testSel       (testSel),
    .testReadAddr  (testReadAddr),
    .testWriteAddr (testWriteAddr),
    .testWriteData (testWriteData),
    .testWriteEn   (testWriteEn),
    .seqReadAddr   (memReadAddr),
    .seqWriteAddr  (memWriteAddr),
    .seqWriteData  (memWriteData),
    .seqWriteEn    (memWriteEn),
    .readData      (memReadData)
  );

  constantRom constantMem (
    .clk     (clk),
    .romAddr (romAddr),
    .romData (romData)
  );

endmodule

// File: tests/lspLsfRef.svh
`ifndef LSP_LSF_REF_SVH
`define LSP_LSF_REF_SVH

// G.729 table2, cos(i*pi/64) in Q15
localparam int COS_TABLE [64] = '{
  32767, 32729, 32610, 32413, 32138, 31786, 31357, 30853,
  30274, 29622, 28899, 28106, 27246, 26320, 25330, 24279,
  23170, 22006, 20788, 19520, 18205, 16846, 15447, 14010,
  12540, 11039, 9512, 7962, 6393, 4808, 3212, 1608,
  0, -1608, -3212, -4808, -6393, -7962, -9512, -11039,
  -12540, -14010, -15447, -16846, -18205, -19520, -20788, -22006,
  -23170, -24279, -25330, -26320, -27246, -28106, -28899, -29622,
  -30274, -30853, -31357, -31786, -32138, -32413, -32610, -32729
};

// G.729 slope_acos
localparam int ACOS_SLOPE [64] = '{
  -26887, -8812, -5323, -3813, -2979, -2444, -2081, -1811,
  -1608, -1450, -1322, -1219, -1132, -1059, -998, -946,
  -901, -861, -827, -797, -772, -750, -730, -713,
  -699, -687, -677, -668, -662, -657, -654, -652,
  -652, -654, -657, -662, -668, -677, -687, -699,
  -713, -730, -750, -772, -797, -827, -861, -901,
  -946, -998, -1059, -1132, -1219, -1322, -1450, -1608,
  -1811, -2081, -2444, -2979, -3813, -5323, -8812, -26887
};

function automatic int clip16(input longint v);
  if (v > 32767)
    return 32767;
  else if (v < -32768)
    return -32768;
  else
    return int'(v);
endfunction

// extract_l
function automatic int lowHalf(input int v);
  logic signed [15:0] h;
  h = v[15:0];
  return h;
endfunction

function automatic int lMult32(input int a, input int b);
  longint p;
  p = longint'(a) * longint'(b) * 2;
  if (p > 2147483647)
    return 2147483647;
  else
    return int'(p);
endfunction

function automatic int lShr32(input int v, input int n);
  return v >>> n;
endfunction

function automatic int shl16(input int v, input int n);
  return clip16(longint'(v) <<< n);
endfunction

function automatic int mult16(input int a, input int b);
  return clip16((longint'(a) * longint'(b)) >>> 15);
endfunction

// lsp_lsf2 on plain integers
task automatic computeLsf(input int lsp [LPC_ORDER], output int lsf [LPC_ORDER]);
  int ind;
  int offset;
  int freq;
  ind = 63;
  for (int i = LPC_ORDER - 1; i >= 0; i--)
  begin
    // Index carries over between coefficients
    while (clip16(longint'(COS_TABLE[ind]) - lsp[i]) < 0)
    begin
      ind--;
      if (ind <= 0)
        break;
    end
    offset = clip16(longint'(lsp[i]) - COS_TABLE[ind]);
    freq = clip16(longint'(shl16(ind, 9))
                  + lowHalf(lShr32(lMult32(ACOS_SLOPE[ind], offset), 12)));
    // 2*pi in Q12
    lsf[i] = mult16(freq, 25736);
  end
endtask

`endif

// File: tests/lspLsfTb.sv
`timescale 1ns/1ns

module lspLsfTb import g729Pkg::*;;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 8;
  localparam int DONE_TIMEOUT = 2000;
  localparam int QUIET_CYCLES = 40;
  localparam int GUARD = 4;
  localparam int NUM_CASES = 7;
  localparam int RANDOM_CASES = 20;
  localparam int SEED = 16247;
  localparam logic [ADDR_W-1:0] LSP_BASE = 12'h040;
  localparam logic [ADDR_W-1:0] LSF_BASE = 12'h080;

  logic              clk;
  logic              rst;
  logic              start;
  logic [ADDR_W-1:0] lspAddr;
  logic [ADDR_W-1:0] lsfAddr;
  logic              testSel;
  logic [ADDR_W-1:0] testReadAddr;
  logic [ADDR_W-1:0] testWriteAddr;
  logic [DATA_W-1:0] testWriteData;
  logic              testWriteEn;
  logic              done;
  logic              busy;
  logic [DATA_W-1:0] memReadData;

  int    seed;
  int    testCount;
  int    failCount;
  int    errorCount;
  bit    hung;
  string caseName [NUM_CASES];
  int    caseLsp [NUM_CASES][LPC_ORDER];
  // Hand-derived LSF for uniform sets and -1 where only the model applies
  int    caseLsf [NUM_CASES];

  `include "lspLsfRef.svh"

  lspLsfPipe dut0 (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .lspAddr       (lspAddr),
    .lsfAddr       (lsfAddr),
    .testSel       (testSel),
    .testReadAddr  (testReadAddr),
    .testWriteAddr (testWriteAddr),
    .testWriteData (testWriteData),
    .testWriteEn   (testWriteEn),
    .done          (done),
    .busy          (busy),
    .memReadData   (memReadData)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Test port access
  ////////////////////////////////////////

  task automatic writeWord(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    testSel = 1'b1;
    testWriteAddr = addr;
    testWriteData = data;
    testWriteEn = 1'b1;
  endtask

  task automatic readWord(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    @(negedge clk);
    testSel = 1'b1;
    testWriteEn = 1'b0;
    testReadAddr = addr;
    @(negedge clk);
    data = memReadData;
  endtask

  task automatic expectWord(input string name, input string what,
                            input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] expected, inout int errs);
    logic [DATA_W-1:0] word;
    readWord(addr, word);
    if (word !== expected)
    begin
      $display("MISMATCH %s %s at %03h expected %08h actual %08h",
               name, what, addr, expected, word);
      errs++;
    end
  endtask

  // Fill word built from the whole address
  function automatic logic [DATA_W-1:0] fillWord(input logic [ADDR_W-1:0] addr);
    return {4'hC, addr, 4'h3, ~addr};
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic loadCases();
    caseName[0] = "spreadA";
    caseLsp[0] = '{30000, 26000, 21000, 15000, 8000, 0, -8000, -15000, -21000, -26000};
    caseLsf[0] = -1;
    caseName[1] = "spreadB";
    caseLsp[1] = '{32000, 29000, 24000, 18000, 11000, 3000, -5000, -13000, -22000, -30000};
    caseLsf[1] = -1;
    caseName[2] = "clustered";
    caseLsp[2] = '{20000, 19800, 19500, 12000, 11900, -2000, -2100, -24000, -24100, -31000};
    caseLsf[2] = -1;
    // Walks the index all the way down to entry 0
    caseName[3] = "allMax";
    caseLsp[3] = '{default: 32767};
    caseLsf[3] = 0;
    // Index stays at entry 63 and the add saturates
    caseName[4] = "allMin";
    caseLsp[4] = '{default: -32768};
    caseLsf[4] = 25735;
    caseName[5] = "allZero";
    caseLsp[5] = '{default: 0};
    caseLsf[5] = 12868;
    caseName[6] = "allEntry16";
    caseLsp[6] = '{default: 23170};
    caseLsf[6] = 6434;
  endtask

  task automatic randomSet(output int lsp [LPC_ORDER]);
    logic signed [15:0] r;
    int j;
    for (int k = 0; k < LPC_ORDER; k++)
    begin
      r = 16'($random(seed));
      j = k;
      // Insertion keeps the set descending
      while (j > 0 && lsp[j-1] < int'(r))
      begin
        lsp[j] = lsp[j-1];
        j--;
      end
      lsp[j] = r;
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic reportTest(input string name, input int errs);
    testCount++;
    errorCount += errs;
    if (errs == 0)
      $display("%-12s ok", name);
    else
    begin
      failCount++;
      $display("%-12s failed with %0d errors", name, errs);
    end
  endtask

  task automatic checkIdle();
    int errs;
    errs = 0;
    for (int c = 0; c < 6; c++)
    begin
      @(negedge clk);
      if (done || busy)
      begin
        $display("resetIdle: done or busy is high before the first start");
        errs++;
      end
    end
    reportTest("resetIdle", errs);
  endtask

  task automatic runCase(input string name, input int lsp [LPC_ORDER], input int fixedLsf);
    int expLsf [LPC_ORDER];
    int errs;
    int cycles;
    errs = 0;
    computeLsf(lsp, expLsf);
    for (int k = 0; k < LPC_ORDER; k++)
    begin
      if (fixedLsf >= 0 && expLsf[k] != fixedLsf)
      begin
        $display("MISMATCH %s model lsf[%0d] expected %0d actual %0d",
                 name, k, fixedLsf, expLsf[k]);
        errs++;
      end
      if (fixedLsf >= 0)
        expLsf[k] = fixedLsf;
    end
    for (int g = -GUARD; g < LPC_ORDER + GUARD; g++)
      writeWord(LSF_BASE + ADDR_W'(g), fillWord(LSF_BASE + ADDR_W'(g)));
    for (int k = 0; k < LPC_ORDER; k++)
      writeWord(LSP_BASE + ADDR_W'(k), lsp[k]);
    @(negedge clk);
    testSel = 1'b0;
    testWriteEn = 1'b0;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (!busy)
    begin
      $display("%s: busy did not rise after start", name);
      errs++;
    end
    cycles = 0;
    // Second start pulse lands while busy
    while (busy && cycles < DONE_TIMEOUT)
    begin
      if (done)
      begin
        $display("%s: done pulsed while busy was still high", name);
        errs++;
      end
      start = (cycles == 2);
      @(negedge clk);
      cycles++;
    end
    start = 1'b0;
    if (busy)
    begin
      $display("%s: no done pulse within %0d cycles", name, DONE_TIMEOUT);
      hung = 1'b1;
      reportTest(name, errs + 1);
      return;
    end
    if (!done)
    begin
      $display("%s: busy went low without a done pulse", name);
      errs++;
    end
    for (int c = 0; c < QUIET_CYCLES; c++)
    begin
      @(negedge clk);
      if (done || busy)
      begin
        $display("%s: extra done or busy after the conversion ended", name);
        errs++;
      end
    end
    for (int k = 0; k < LPC_ORDER; k++)
      expectWord(name, "lsf", LSF_BASE + ADDR_W'(k), expLsf[k], errs);
    for (int g = 1; g <= GUARD; g++)
    begin
      expectWord(name, "guard", LSF_BASE - ADDR_W'(g), fillWord(LSF_BASE - ADDR_W'(g)), errs);
      expectWord(name, "guard", LSF_BASE + ADDR_W'(LPC_ORDER + g - 1),
                 fillWord(LSF_BASE + ADDR_W'(LPC_ORDER + g - 1)), errs);
    end
    for (int k = 0; k < LPC_ORDER; k++)
      expectWord(name, "lsp", LSP_BASE + ADDR_W'(k), lsp[k], errs);
    reportTest(name, errs);
  endtask

  initial
  begin
    int rnd [LPC_ORDER];
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    lspAddr = LSP_BASE;
    lsfAddr = LSF_BASE;
    testSel = 1'b1;
    testReadAddr = '0;
    testWriteAddr = '0;
    testWriteData = '0;
    testWriteEn = 1'b0;
    seed = SEED;
    testCount = 0;
    failCount = 0;
    errorCount = 0;
    hung = 1'b0;
    loadCases();
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    checkIdle();
    for (int t = 0; t < NUM_CASES; t++)
    begin
      if (!hung)
        runCase(caseName[t], caseLsp[t], caseLsf[t]);
    end
    for (int r = 0; r < RANDOM_CASES; r++)
    begin
      randomSet(rnd);
      if (!hung)
        runCase($sformatf("random%0d", r), rnd, -1);
    end
    $display("%0d tests, %0d failed, %0d errors", testCount, failCount, errorCount);
    if (errorCount == 0 && !hung)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: common/lspTables.mem
// One word per table index, index 0 first
// Bits 31..16 hold the cosine entry and bits 15..0 hold the acos slope
7FFF96F9
7FD9DD94
7F62EB35
7E9DF11B
7D8AF45D
7C2AF674
7A7DF7DF
7885F8ED
7642F9B8
73B6FA56
70E3FAD6
6DCAFB3D
6A6EFB94
66D0FBDD
62F2FC1A
5ED7FC4E
5A82FC7B
55F6FCA3
5134FCC5
4C40FCE3
471DFCFC
41CEFD12
3C57FD26
36BAFD37
30FCFD45
2B1FFD51
2528FD5B
1F1AFD64
18F9FD6A
12C8FD6F
0C8CFD72
0648FD74
0000FD74
F9B8FD72
F374FD6F
ED38FD6A
E707FD64
E0E6FD5B
DAD8FD51
D4E1FD45
CF04FD37
C946FD26
C3A9FD12
BE32FCFC
B8E3FCE3
B3C0FCC5
AECCFCA3
AA0AFC7B
A57EFC4E
A129FC1A
9D0EFBDD
9930FB94
9592FB3D
9236FAD6
8F1DFA56
8C4AF9B8
89BEF8ED
877BF7DF
8583F674
83D6F45D
8276F11B
8163EB35
809EDD94
802796F9

// File: vlog.f
+incdir+tests
common/g729Pkg.sv
verilog/basicOps.sv
verilog/scratchMemory.sv
verilog/constantRom.sv
lspLsf/lspLsfControl.sv
lspLsf/lspLsfPipe.sv
tests/lspLsfTb.sv

// File: Makefile
# Verilator build of the LSP to LSF testbench

VERILATOR ?= verilator
TOP       ?= lspLsfTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from searching the simulator output for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
